// File: hdl/sdmacPkg.sv
// SDMAC shared definitions
package sdmacPkg;

    typedef logic [7:0]  scsiByteT;                     // One byte on the SCSI data bus
    typedef logic [31:0] longWordT;                     // FIFO entry and APB data word
    typedef logic [7:0]  apbAddrT;                      // APB byte address
    typedef logic [4:0]  scsiRegT;                      // Register number inside the chip

    // APB register map
    localparam apbAddrT REG_CTRL      = 8'h00;          // Bit 0 dmaDir, bit 1 dmaEn
    localparam apbAddrT REG_STATUS    = 8'h04;          // Empty, full, count in 15:8
    localparam apbAddrT REG_FIFO      = 8'h08;          // Host side of the longword FIFO
    localparam apbAddrT REG_SCSI_BASE = 8'h80;          // Chip window, reg number in 6:2

    // Strobe widths in BCLK cycles
    localparam int CPU_STROBE_CYCLES = 2;               // RE/WE width for CPU register cycles
    localparam int DMA_STROBE_CYCLES = 2;               // RE/WE width with DACK

    typedef enum logic [2:0] {
        SM_IDLE,                                        // Arbitrate CPU over DMA
        SM_CPU_SETUP,                                   // CS, address and data out
        SM_CPU_STROBE,                                  // RE or WE active
        SM_CPU_HOLD,                                    // CS held, strobe released
        SM_DMA_STROBE,                                  // DACK with RE or WE
        SM_DMA_RECOVER                                  // Everything low for one cycle
    } scsiStateT;

endpackage

// File: hdl/apbRegs.sv
// APB register block
`timescale 1ns/1ps

module apbRegs import sdmacPkg::*; #(
    parameter int FIFO_DEPTH = 8                        // Longwords in the FIFO
) (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  apbAddrT                     paddr_i,
    input  longWordT                    pwdata_i,
    output longWordT                    prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  logic                        cpuDone_i,      // Chip cycle finished
    input  scsiByteT                    cpuRdata_i,     // Byte read from the chip
    input  longWordT                    hostRdata_i,    // FIFO head longword
    input  logic                        fifoEmpty_i,
    input  logic                        fifoFull_i,
    input  logic [$clog2(FIFO_DEPTH):0] fifoCount_i,
    output logic                        cpuReq_o,       // Held until cpuDone_i
    output logic                        cpuWrite_o,
    output scsiRegT                     cpuReg_o,
    output scsiByteT                    cpuWdata_o,
    output logic                        dmaDir_o,       // 1 = SCSI to FIFO
    output logic                        dmaEn_o,
    output logic                        hostPush_o,
    output longWordT                    hostWdata_o,
    output logic                        hostPop_o
);

    logic     accPhase;                                 // APB access phase
    logic     isCtrl, isStatus, isFifo, isWindow;       // Address decode
    logic     unmapped;                                 // No register at this address
    logic     fifoErr;                                  // Illegal FIFO access
    logic     winDoneQ;                                 // Chip cycle done, release PREADY
    longWordT statusWord;

    assign accPhase = psel_i & penable_i;
    assign isCtrl   = (paddr_i == REG_CTRL);
    assign isStatus = (paddr_i == REG_STATUS);
    assign isFifo   = (paddr_i == REG_FIFO);
    assign isWindow = (paddr_i >= REG_SCSI_BASE) && (paddr_i[1:0] == 2'b00); // Word aligned only
    assign unmapped = !(isCtrl | isStatus | isFifo | isWindow);

    // FIFO belongs to the DMA while dmaEn is set
    assign fifoErr = isFifo & (dmaEn_o | (pwrite_i ? fifoFull_i : fifoEmpty_i));

    assign cpuReq_o    = accPhase & isWindow & !winDoneQ; // Drops once PREADY goes out
    assign cpuWrite_o  = pwrite_i;
    assign cpuReg_o    = paddr_i[6:2];
    assign cpuWdata_o  = pwdata_i[7:0];
    assign hostWdata_o = pwdata_i;
    assign hostPush_o  = accPhase & isFifo & pwrite_i & !fifoErr;
    assign hostPop_o   = accPhase & isFifo & !pwrite_i & !fifoErr;

    assign pready_o  = accPhase & (isWindow ? winDoneQ : 1'b1); // Window waits for the chip
    assign pslverr_o = accPhase & !isWindow & (unmapped | fifoErr);

    always_comb begin
        statusWord                          = '0;
        statusWord[0]                       = fifoEmpty_i;
        statusWord[1]                       = fifoFull_i;
        statusWord[8 +: $bits(fifoCount_i)] = fifoCount_i; // Longword count
    end

    always_comb begin
        prdata_o = '0;
        if (isCtrl) begin
            prdata_o[1:0] = {dmaEn_o, dmaDir_o};
        end else if (isStatus) begin
            prdata_o = statusWord;
        end else if (isFifo) begin
            prdata_o = hostRdata_i;
        end else if (isWindow) begin
            prdata_o[7:0] = cpuRdata_i;                 // Latched by the sequencer
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dmaDir_o <= 1'b0;
            dmaEn_o  <= 1'b0;
            winDoneQ <= 1'b0;
        end else begin
            winDoneQ <= cpuDone_i;                      // One cycle, ends the transfer
            if (accPhase & isCtrl & pwrite_i) begin
                dmaDir_o <= pwdata_i[0];
                dmaEn_o  <= pwdata_i[1];
            end
        end
    end

    // Access phase must follow a setup phase
    apbSetupFirst: assert property (@(posedge BCLK) disable iff (!CRESET_)
        $rose(penable_i) |-> $past(psel_i));

endmodule

// File: hdl/dmaFifo.sv
// Longword DMA FIFO
`timescale 1ns/1ps

module dmaFifo import sdmacPkg::*; #(
    parameter int FIFO_DEPTH = 8                        // Power of two, 2 to 64
) (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    input  logic                        dmaDir_i,       // 1 = SCSI to FIFO
    input  logic                        hostPush_i,
    input  longWordT                    hostWdata_i,
    input  logic                        hostPop_i,
    input  logic                        byteIn_i,       // S2F byte strobe
    input  scsiByteT                    byteInData_i,
    input  logic                        byteOut_i,      // F2S byte taken
    output logic                        byteInReady_o,
    output scsiByteT                    byteOutData_o,
    output logic                        byteOutValid_o,
    output longWordT                    hostRdata_o,
    output logic                        fifoEmpty_o,
    output logic                        fifoFull_o,
    output logic [$clog2(FIFO_DEPTH):0] fifoCount_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    longWordT         mem [FIFO_DEPTH];                 // Longword store
    logic [PTR_W-1:0] nextIn;                           // Next in pointer
    logic [PTR_W-1:0] nextOut;                          // Next out pointer
    logic [PTR_W:0]   count;
    logic [1:0]       bytePtr;                          // Byte lane, 0 first
    logic [23:0]      asmBytes;                         // Lanes 0..2 of the word being packed
    logic             dmaDirQ;                          // Detects dmaDir falling
    logic             byteCommit, bytePop;              // Lane 3 reached
    logic             memWrite, memRead;
    longWordT         writeWord;

    assign byteCommit = byteIn_i & (bytePtr == 2'd3);
    assign bytePop    = byteOut_i & (bytePtr == 2'd3);
    assign memWrite   = hostPush_i | byteCommit;
    assign memRead    = hostPop_i | bytePop;
    assign writeWord  = byteCommit ? {byteInData_i, asmBytes} : hostWdata_i; // Little endian

    assign fifoEmpty_o    = (count == '0);
    assign fifoFull_o     = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign fifoCount_o    = count;
    assign byteInReady_o  = !fifoFull_o;
    assign byteOutValid_o = !fifoEmpty_o;
    assign hostRdata_o    = mem[nextOut];
    assign byteOutData_o  = mem[nextOut][{bytePtr, 3'b000} +: 8]; // Current outgoing lane

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            count   <= '0;
            bytePtr <= '0;
            dmaDirQ <= 1'b0;
        end else begin
            dmaDirQ <= dmaDir_i;
            if (memWrite) nextIn <= nextIn + 1'b1;      // Wraps at depth
            if (memRead) nextOut <= nextOut + 1'b1;
            count <= count + {{PTR_W{1'b0}}, memWrite} - {{PTR_W{1'b0}}, memRead};
            if (dmaDirQ && !dmaDir_i) begin
                bytePtr <= '0;                          // Direction cleared, restart lanes
            end else if (byteIn_i || byteOut_i) begin
                bytePtr <= bytePtr + 2'd1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (memWrite) mem[nextIn] <= writeWord;
        if (byteIn_i && bytePtr != 2'd3) begin
            asmBytes[{bytePtr, 3'b000} +: 8] <= byteInData_i; // Pack lanes 0..2
        end
    end

    // Overflow and underflow from either side
    noCommitFull: assert property (@(posedge BCLK) disable iff (!CRESET_)
        memWrite |-> !fifoFull_o);
    noPopEmpty: assert property (@(posedge BCLK) disable iff (!CRESET_)
        memRead |-> !fifoEmpty_o);

endmodule

// File: hdl/scsiSm.sv
// SCSI chip sequencer
`timescale 1ns/1ps

module scsiSm import sdmacPkg::*; (
    input  logic     BCLK,
    input  logic     CRESET_,
    input  logic     cpuReq_i,                          // CPU register cycle wanted
    input  logic     cpuWrite_i,
    input  scsiRegT  cpuReg_i,
    input  scsiByteT cpuWdata_i,
    input  logic     dmaDir_i,                          // 1 = SCSI to FIFO
    input  logic     dmaEn_i,
    input  logic     dreq_i,                            // Chip has a DMA byte ready
    input  scsiByteT scsiData_i,
    input  logic     byteInReady_i,                     // FIFO can take a byte
    input  logic     byteOutValid_i,                    // FIFO has a byte
    input  scsiByteT byteOutData_i,
    output logic     cpuDone_o,                         // One cycle pulse
    output scsiByteT cpuRdata_o,
    output logic     scsiCs_o,
    output logic     scsiRe_o,
    output logic     scsiWe_o,
    output scsiRegT  scsiAddr_o,
    output scsiByteT scsiData_o,
    output logic     scsiDataOe_o,                      // Drive the chip data bus
    output logic     dack_o,
    output logic     byteIn_o,                          // Hand a byte to the FIFO
    output scsiByteT byteInData_o,
    output logic     byteOut_o                          // Byte taken from the FIFO
);

    scsiStateT  state;
    logic [3:0] strobeCnt;                              // Remaining strobe cycles
    logic       startCpu;
    logic       startDma;
    logic       strobeLast;

    assign startCpu   = cpuReq_i & !cpuDone_o;          // Request still up while done returns
    assign startDma   = dmaEn_i & dreq_i & !cpuReq_i &
                        (dmaDir_i ? byteInReady_i : byteOutValid_i); // CPU has priority
    assign strobeLast = (strobeCnt == '0);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state        <= SM_IDLE;
            strobeCnt    <= '0;
            cpuDone_o    <= 1'b0;
            scsiCs_o     <= 1'b0;
            scsiRe_o     <= 1'b0;
            scsiWe_o     <= 1'b0;
            scsiDataOe_o <= 1'b0;
            dack_o       <= 1'b0;
            byteIn_o     <= 1'b0;
            byteOut_o    <= 1'b0;
        end else begin
            cpuDone_o <= 1'b0;                          // Pulses by default
            byteIn_o  <= 1'b0;
            byteOut_o <= 1'b0;
            case (state)
                SM_IDLE: begin
                    if (startCpu) begin
                        state        <= SM_CPU_SETUP;
                        scsiCs_o     <= 1'b1;
                        scsiDataOe_o <= cpuWrite_i;
                    end else if (startDma) begin
                        state        <= SM_DMA_STROBE;
                        strobeCnt    <= 4'(DMA_STROBE_CYCLES - 1);
                        dack_o       <= 1'b1;
                        scsiRe_o     <= dmaDir_i;       // Read chip for S2F
                        scsiWe_o     <= !dmaDir_i;      // Write chip for F2S
                        scsiDataOe_o <= !dmaDir_i;
                    end
                end
                SM_CPU_SETUP: begin
                    state     <= SM_CPU_STROBE;
                    strobeCnt <= 4'(CPU_STROBE_CYCLES - 1);
                    scsiRe_o  <= !cpuWrite_i;
                    scsiWe_o  <= cpuWrite_i;
                end
                SM_CPU_STROBE: begin
                    if (strobeLast) begin
                        state    <= SM_CPU_HOLD;
                        scsiRe_o <= 1'b0;
                        scsiWe_o <= 1'b0;
                    end else begin
                        strobeCnt <= strobeCnt - 4'd1;
                    end
                end
                SM_CPU_HOLD: begin
                    state        <= SM_IDLE;
                    scsiCs_o     <= 1'b0;
                    scsiDataOe_o <= 1'b0;
                    cpuDone_o    <= 1'b1;
                end
                SM_DMA_STROBE: begin
                    if (strobeLast) begin
                        state        <= SM_DMA_RECOVER;
                        dack_o       <= 1'b0;
                        scsiRe_o     <= 1'b0;
                        scsiWe_o     <= 1'b0;
                        scsiDataOe_o <= 1'b0;
                        byteIn_o     <= dmaDir_i;
                        byteOut_o    <= !dmaDir_i;
                    end else begin
                        strobeCnt <= strobeCnt - 4'd1;
                    end
                end
                SM_DMA_RECOVER: state <= SM_IDLE;       // FIFO pointers settle here
                default: state <= SM_IDLE;
            endcase
        end
    end

    // Bus address and data
    always_ff @(posedge BCLK) begin
        if (state == SM_IDLE && startCpu) begin
            scsiAddr_o <= cpuReg_i;
            scsiData_o <= cpuWdata_i;
        end else if (state == SM_IDLE && startDma) begin
            scsiData_o <= byteOutData_i;                // Lane picked by the FIFO byte pointer
        end
        if (state == SM_CPU_STROBE && strobeLast) cpuRdata_o <= scsiData_i;   // Last RE edge
        if (state == SM_DMA_STROBE && strobeLast) byteInData_o <= scsiData_i;
    end

    // Chip side strobe rules
    reWeExclusive: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(scsiRe_o && scsiWe_o));
    dackNotCs: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(dack_o && scsiCs_o));

endmodule

// File: hdl/sdmacTop.sv
// SDMAC top level
`timescale 1ns/1ps

module sdmacTop import sdmacPkg::*; #(
    parameter int FIFO_DEPTH = 8                        // Longwords in the FIFO
) (
    input  logic     BCLK,
    input  logic     CRESET_,
    input  logic     psel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  apbAddrT  paddr_i,
    input  longWordT pwdata_i,
    output longWordT prdata_o,
    output logic     pready_o,
    output logic     pslverr_o,
    output logic     scsiCs_o,
    output logic     scsiRe_o,
    output logic     scsiWe_o,
    output scsiRegT  scsiAddr_o,
    output scsiByteT scsiData_o,
    output logic     scsiDataOe_o,
    output logic     dack_o,
    input  logic     dreq_i,
    input  scsiByteT scsiData_i
);

    logic                        cpuReq, cpuWrite, cpuDone;  // CPU register cycle
    scsiRegT                     cpuReg;
    scsiByteT                    cpuWdata, cpuRdata;
    logic                        dmaDir, dmaEn;
    logic                        hostPush, hostPop;          // Host side of the FIFO
    longWordT                    hostWdata, hostRdata;
    logic                        fifoEmpty, fifoFull;
    logic [$clog2(FIFO_DEPTH):0] fifoCount;
    logic                        byteIn, byteInReady;        // S2F lane
    scsiByteT                    byteInData;
    logic                        byteOut, byteOutValid;      // F2S lane
    scsiByteT                    byteOutData;

    apbRegs #(.FIFO_DEPTH(FIFO_DEPTH)) i_apbRegs (
        .BCLK, .CRESET_, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .cpuDone_i(cpuDone), .cpuRdata_i(cpuRdata), .hostRdata_i(hostRdata),
        .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull), .fifoCount_i(fifoCount),
        .cpuReq_o(cpuReq), .cpuWrite_o(cpuWrite), .cpuReg_o(cpuReg), .cpuWdata_o(cpuWdata),
        .dmaDir_o(dmaDir), .dmaEn_o(dmaEn),
        .hostPush_o(hostPush), .hostWdata_o(hostWdata), .hostPop_o(hostPop)
    );

    scsiSm i_scsiSm (
        .BCLK, .CRESET_,
        .cpuReq_i(cpuReq), .cpuWrite_i(cpuWrite), .cpuReg_i(cpuReg), .cpuWdata_i(cpuWdata),
        .dmaDir_i(dmaDir), .dmaEn_i(dmaEn), .dreq_i, .scsiData_i,
        .byteInReady_i(byteInReady), .byteOutValid_i(byteOutValid),
        .byteOutData_i(byteOutData),
        .cpuDone_o(cpuDone), .cpuRdata_o(cpuRdata),
        .scsiCs_o, .scsiRe_o, .scsiWe_o, .scsiAddr_o, .scsiData_o, .scsiDataOe_o, .dack_o,
        .byteIn_o(byteIn), .byteInData_o(byteInData), .byteOut_o(byteOut)
    );

    dmaFifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_dmaFifo (
        .BCLK, .CRESET_, .dmaDir_i(dmaDir),
        .hostPush_i(hostPush), .hostWdata_i(hostWdata), .hostPop_i(hostPop),
        .byteIn_i(byteIn), .byteInData_i(byteInData), .byteOut_i(byteOut),
        .byteInReady_o(byteInReady), .byteOutData_o(byteOutData),
        .byteOutValid_o(byteOutValid), .hostRdata_o(hostRdata),
        .fifoEmpty_o(fifoEmpty), .fifoFull_o(fifoFull), .fifoCount_o(fifoCount)
    );

endmodule

// File: dv/clkGen.sv
// Clock and reset source
`timescale 1ns/1ps

module clkGen (
    output logic BCLK,
    output logic CRESET_
);

    initial begin
        BCLK = 1'b0;
        forever #20 BCLK = ~BCLK;                       // 40 ns period
    end

    initial begin
        CRESET_ = 1'b0;                                 // Asserted from time zero
        repeat (10) @(posedge BCLK);
        @(negedge BCLK);
        CRESET_ = 1'b1;                                 // Released away from the active edge
    end

endmodule

// File: dv/scsiDevModel.sv
// Behavioral SCSI chip
`timescale 1ns/1ps

module scsiDevModel import sdmacPkg::*; (
    input  logic     BCLK,
    input  logic     scsiCs_i,
    input  logic     scsiRe_i,
    input  logic     scsiWe_i,
    input  scsiRegT  scsiAddr_i,
    input  scsiByteT scsiData_i,                        // Bus driven by the DUT
    input  logic     dack_i,
    output logic     dreq_o,
    output scsiByteT scsiData_o                         // Bus driven by the chip
);

    scsiByteT regs [32];                                // Chip register file
    scsiByteT srcMem [256];                             // S2F bytes waiting to go out
    scsiByteT sinkMem [256];                            // F2S bytes received
    int       srcHead = 0;
    int       srcTail = 0;
    int       sinkCount = 0;
    int       sinkRoom = 0;                             // F2S bytes still accepted
    int       accessCnt = 0;                            // CPU register cycles seen
    scsiRegT  lastReg = '0;
    logic     lastWrite = 1'b0;
    logic     cpuStrobeQ = 1'b0;
    logic     dmaReadQ = 1'b0;
    logic     dackQ = 1'b0;

    assign dreq_o     = (srcHead != srcTail) || (sinkRoom > 0); // Pending work
    assign scsiData_o = (dack_i && scsiRe_i)   ? srcMem[srcHead % 256] :
                        (scsiCs_i && scsiRe_i) ? regs[scsiAddr_i] : 8'h00;

    initial begin
        for (int i = 0; i < 32; i++) regs[i] = scsiByteT'(i * 37 + 5); // Distinct per register
    end

    task automatic offerByte(input scsiByteT b);
        srcMem[srcTail % 256] = b;
        srcTail++;
    endtask

    task automatic setSinkRoom(input int n);
        sinkRoom = n;
    endtask

    always @(negedge BCLK) begin
        if (scsiCs_i && (scsiRe_i || scsiWe_i) && !cpuStrobeQ) begin // Strobe start
            accessCnt++;
            lastReg   = scsiAddr_i;
            lastWrite = scsiWe_i;
            if (scsiWe_i) regs[scsiAddr_i] = scsiData_i;
        end
        if (dack_i && !dackQ && scsiWe_i) begin         // F2S byte on the bus
            sinkMem[sinkCount % 256] = scsiData_i;
            sinkCount++;
            if (sinkRoom > 0) sinkRoom--;
        end
        if (dmaReadQ && !dack_i) srcHead++;             // S2F byte taken on the last edge
        cpuStrobeQ = scsiCs_i && (scsiRe_i || scsiWe_i);
        dmaReadQ   = dack_i && scsiRe_i;
        dackQ      = dack_i;
    end

endmodule

// File: dv/tbSdmac.sv
// SDMAC testbench
`timescale 1ns/1ps

module tbSdmac import sdmacPkg::*; ();

    localparam int FIFO_DEPTH = 8;
    localparam int TIMEOUT    = 400;                    // Cycles or polls per wait

    logic        BCLK, CRESET_;
    logic        psel, penable, pwrite, pready, pslverr;
    apbAddrT     paddr;
    longWordT    pwdata, prdata, rd;
    logic        scsiCs, scsiRe, scsiWe, scsiDataOe, dack, dreq;
    scsiRegT     scsiAddr;
    scsiByteT    scsiDataOut, scsiDataIn;
    logic [31:0] rngState = 32'd84;
    scsiByteT    expRegs [32];                          // Expected chip registers
    scsiByteT    offerLog [256];                        // S2F bytes in offered order
    int          offerCount = 0;
    int          checkIdx = 0;                          // Next S2F byte to compare
    longWordT    words [FIFO_DEPTH];
    int          sinkStart;

    clkGen i_clkGen (.BCLK, .CRESET_);

    sdmacTop #(.FIFO_DEPTH(FIFO_DEPTH)) i_sdmacTop (
        .BCLK, .CRESET_, .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .scsiCs_o(scsiCs), .scsiRe_o(scsiRe), .scsiWe_o(scsiWe),
        .scsiAddr_o(scsiAddr), .scsiData_o(scsiDataOut), .scsiDataOe_o(scsiDataOe),
        .dack_o(dack), .dreq_i(dreq), .scsiData_i(scsiDataIn)
    );

    scsiDevModel i_dev (
        .BCLK, .scsiCs_i(scsiCs), .scsiRe_i(scsiRe), .scsiWe_i(scsiWe),
        .scsiAddr_i(scsiAddr), .scsiData_i(scsiDataOut), .dack_i(dack),
        .dreq_o(dreq), .scsiData_o(scsiDataIn)
    );

    task automatic stopOnError();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkHex(input string name, input longWordT got, input longWordT exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic timedOut(input string what);
        $display("Timed out while waiting for %s", what);
        stopOnError();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic longWordT randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic apbAccess(input logic write, input apbAddrT addr, input longWordT wdata,
                             output longWordT rdata, output logic err);
        int waitCycles;
        waitCycles = 0;
        @(negedge BCLK);
        psel    = 1'b1;                                 // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge BCLK);
        penable = 1'b1;                                 // Access phase
        #1;
        while (!pready) begin
            if (waitCycles >= TIMEOUT) timedOut("pready_o");
            @(negedge BCLK);
            #1;
            waitCycles++;
        end
        rdata = prdata;                                 // Stable until the completing edge
        err   = pslverr;
        @(negedge BCLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input longWordT data, input logic expErr);
        longWordT unused;
        logic     err;
        apbAccess(1'b1, addr, data, unused, err);
        checkHex("pslverr_o", err, expErr);
    endtask

    task automatic apbRead(input apbAddrT addr, output longWordT data, input logic expErr);
        logic err;
        apbAccess(1'b0, addr, '0, data, err);
        checkHex("pslverr_o", err, expErr);
    endtask

    task automatic windowAccess(input logic write, input scsiRegT r);
        longWordT wdata;
        longWordT data;
        int       cntBefore;
        wdata     = randWord();
        cntBefore = i_dev.accessCnt;
        if (write) begin
            apbWrite(REG_SCSI_BASE | {1'b0, r, 2'b00}, wdata, 1'b0);
            expRegs[r] = wdata[7:0];                    // Only the low byte reaches the chip
        end else begin
            apbRead(REG_SCSI_BASE | {1'b0, r, 2'b00}, data, 1'b0);
            checkHex("prdata_o", data, {24'h0, expRegs[r]});
        end
        checkHex("device access count", i_dev.accessCnt, cntBefore + 1);
        checkHex("scsiAddr_o", i_dev.lastReg, r);
        checkHex("scsiWe_o", i_dev.lastWrite, write);
    endtask

    task automatic offerBytes(input int n);
        scsiByteT b;
        for (int i = 0; i < n; i++) begin
            b = scsiByteT'(randWord());
            offerLog[offerCount % 256] = b;
            offerCount++;
            i_dev.offerByte(b);
        end
    endtask

    task automatic waitFifoCount(input int n);
        longWordT st;
        int       polls;
        polls = 0;
        apbRead(REG_STATUS, st, 1'b0);
        while (int'(st[15:8]) != n) begin
            if (polls >= TIMEOUT) timedOut("the FIFO longword count");
            apbRead(REG_STATUS, st, 1'b0);
            polls++;
        end
    endtask

    task automatic waitSinkCount(input int n);
        int cycles;
        cycles = 0;
        while (i_dev.sinkCount < n) begin
            if (cycles >= TIMEOUT) timedOut("F2S bytes at the device");
            @(posedge BCLK);
            cycles++;
        end
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (CRESET_ !== 1'b1) begin
            if (cycles >= TIMEOUT) timedOut("reset release");
            @(posedge BCLK);
            cycles++;
        end
    endtask

    // Longwords must be groups of 4 offered bytes, byte 0 in the low lane
    task automatic drainS2f(input int n);
        longWordT data;
        longWordT exp;
        for (int k = 0; k < n; k++) begin
            apbRead(REG_FIFO, data, 1'b0);
            exp = {offerLog[checkIdx + 3], offerLog[checkIdx + 2],
                   offerLog[checkIdx + 1], offerLog[checkIdx]};
            checkHex("prdata_o", data, exp);
            checkIdx += 4;
        end
    endtask

    // Chip data bus is driven by the DUT during write strobes, released during reads
    always @(negedge BCLK) begin
        if (CRESET_ === 1'b1 && scsiWe === 1'b1) checkHex("scsiDataOe_o", scsiDataOe, 1);
        if (CRESET_ === 1'b1 && scsiRe === 1'b1) checkHex("scsiDataOe_o", scsiDataOe, 0);
    end

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        waitReset();
        @(negedge BCLK);
        checkHex("scsiCs_o", scsiCs, 0);
        checkHex("scsiRe_o", scsiRe, 0);
        checkHex("scsiWe_o", scsiWe, 0);
        checkHex("dack_o", dack, 0);
        checkHex("scsiDataOe_o", scsiDataOe, 0);
        checkHex("pready_o", pready, 0);
        checkHex("pslverr_o", pslverr, 0);
        apbRead(REG_STATUS, rd, 1'b0);
        checkHex("prdata_o", rd, 32'h1);                // Empty, count 0

        for (int r = 0; r < 32; r++) windowAccess(1'b1, scsiRegT'(r)); // Fill the model
        for (int i = 0; i < 32; i++) begin
            rd = randWord();
            windowAccess(rd[8], rd[4:0]);
        end

        // Flags and slave errors with the DMA off
        apbWrite(REG_CTRL, 32'h0, 1'b0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            words[i] = randWord();
            apbWrite(REG_FIFO, words[i], 1'b0);
        end
        apbRead(REG_STATUS, rd, 1'b0);
        checkHex("prdata_o", rd, (FIFO_DEPTH << 8) | 32'h2);
        apbWrite(REG_FIFO, randWord(), 1'b1);           // Overflow
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            apbRead(REG_FIFO, rd, 1'b0);
            checkHex("prdata_o", rd, words[i]);
        end
        apbRead(REG_FIFO, rd, 1'b1);                    // Underflow
        apbRead(8'h0C, rd, 1'b1);
        apbWrite(8'h82, 32'h0, 1'b1);                   // Misaligned window
        apbWrite(REG_CTRL, 32'h2, 1'b0);
        apbRead(REG_CTRL, rd, 1'b0);
        checkHex("prdata_o", rd, 32'h2);
        apbWrite(REG_FIFO, randWord(), 1'b1);           // FIFO owned by the DMA
        apbWrite(REG_CTRL, 32'h0, 1'b0);

        // F2S, bytes leave in lane order
        for (int i = 0; i < 4; i++) begin
            words[i] = randWord();
            apbWrite(REG_FIFO, words[i], 1'b0);
        end
        sinkStart = i_dev.sinkCount;
        i_dev.setSinkRoom(16);
        apbWrite(REG_CTRL, 32'h2, 1'b0);
        waitSinkCount(sinkStart + 16);
        waitFifoCount(0);
        apbWrite(REG_CTRL, 32'h0, 1'b0);
        for (int i = 0; i < 16; i++) begin
            checkHex("scsiData_o", i_dev.sinkMem[sinkStart + i],
                     (words[i / 4] >> (8 * (i % 4))) & 32'hFF);
        end

        // S2F past full, rest stays pending at the device
        offerBytes(4 * FIFO_DEPTH + 8);
        apbWrite(REG_CTRL, 32'h3, 1'b0);
        waitFifoCount(FIFO_DEPTH);
        checkHex("dreq_i", dreq, 1);
        apbWrite(REG_CTRL, 32'h1, 1'b0);
        drainS2f(FIFO_DEPTH);
        apbWrite(REG_CTRL, 32'h3, 1'b0);
        waitFifoCount(2);
        apbWrite(REG_CTRL, 32'h1, 1'b0);
        drainS2f(2);

        // Window traffic while S2F runs
        offerBytes(4 * FIFO_DEPTH);
        apbWrite(REG_CTRL, 32'h3, 1'b0);
        for (int i = 0; i < 12; i++) begin
            rd = randWord();
            windowAccess(rd[8], rd[4:0]);
        end
        waitFifoCount(FIFO_DEPTH);
        apbWrite(REG_CTRL, 32'h1, 1'b0);
        drainS2f(FIFO_DEPTH);
        apbRead(REG_STATUS, rd, 1'b0);
        checkHex("prdata_o", rd, 32'h1);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: flist.f
hdl/sdmacPkg.sv
hdl/apbRegs.sv
hdl/dmaFifo.sv
hdl/scsiSm.sv
hdl/sdmacTop.sv
dv/clkGen.sv
dv/scsiDevModel.sv
dv/tbSdmac.sv
